// ==== sim.f ====
+incdir+.
isa_pkg.sv
flow_pkg.sv
exec_ifs.sv
exec_instr_fifo.sv
exec_regfile.sv
exec_alu.sv
exec_ctrl.sv
exec_top.sv
tb_exec_top.sv

// ==== Makefile ====
# Verilator build and run for the execute engine testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' sim.f) exec_cfg.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): sim.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx 'TEST PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_exec_top.sv ====
// ****************************************
// execute engine testbench
// random credit-flow traffic vs reference model
// ****************************************
`include "exec_cfg.svh"

module tb_exec_top
  import isa_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_INSTR    = 300;
  localparam int MAX_CYCLES = 20000;

  logic                    clk;
  logic                    rst_b;
  logic                    in_valid;
  logic [`EXEC_DATA_W-1:0] in_instr;
  logic                    out_credit;
  logic                    in_credit;
  logic                    out_valid;
  logic [`EXEC_REG_AW-1:0] out_rd;
  logic [`EXEC_DATA_W-1:0] out_data;

  // reference model state
  logic [`EXEC_DATA_W-1:0] model_regs [`EXEC_REG_N];
  logic [`EXEC_REG_AW-1:0] exp_rd_q [$];
  logic [`EXEC_DATA_W-1:0] exp_data_q [$];
  logic [31:0]             lcg_state = 32'd63118;

  // sender and receiver bookkeeping
  int issued;
  int snd_credits;
  int rcv_held;
  int idle_gap;
  int ret_gap;
  int cycle;

  exec_top i_exec_top (
    .clk(clk), .rst_b(rst_b), .in_valid(in_valid), .in_instr(in_instr),
    .out_credit(out_credit), .in_credit(in_credit), .out_valid(out_valid),
    .out_rd(out_rd), .out_data(out_data)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // fields from the high lcg bits, low bits repeat too quickly
  function automatic logic [31:0] make_instr();
    logic [31:0] r;
    logic [31:0] w;
    r = next_rand();
    w[31:28] = r[31:28];
    r = next_rand();
    w[27:16] = r[31:20];
    r = next_rand();
    w[15:0] = r[31:16];
    return w;
  endfunction

  // opcode rules, returns 0 for codes with no operation
  function automatic bit model_exec(input logic [3:0] op, input logic [31:0] a,
                                    input logic [31:0] b, input logic [15:0] imm,
                                    output logic [31:0] res);
    logic [4:0] sh;
    sh  = b[4:0];
    res = '0;
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a + ~b + 32'd1;
      // signs differ means the negative one is smaller
      OP_SLT:  res = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      OP_SLTU: res = {31'b0, a < b};
      OP_SLL:  res = a << sh;
      OP_SRL:  res = a >> sh;
      OP_SRA: begin
        res = a >> sh;
        if (a[31])
          res = res | ~(32'hffff_ffff >> sh);
      end
      OP_ADDI: res = a + {{16{imm[15]}}, imm};
      OP_LUI:  res = {imm, 16'h0000};
      default: return 1'b0;
    endcase
    return 1'b1;
  endfunction

  // in-order engine, so the model runs at issue time
  function automatic void model_issue(input logic [31:0] w);
    logic [31:0] res;
    if (model_exec(w[31:28], model_regs[w[24:22]], model_regs[w[21:19]], w[15:0], res)) begin
      model_regs[w[27:25]] = res;
      exp_rd_q.push_back(w[27:25]);
      exp_data_q.push_back(res);
    end
  endfunction

  task automatic stop_run(input string why);
    $display("error at %0t ns: %s", $time, why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  function automatic bit drained();
    return (issued == N_INSTR) && (exp_rd_q.size() == 0) &&
           (snd_credits == `EXEC_FIFO_DEPTH) && (rcv_held == 0);
  endfunction

  // one clock edge, outputs sampled as held over the past cycle
  task automatic cycle_step();
    logic [31:0] w;
    logic [31:0] r;
    // queue returned a credit
    if (in_credit)
      snd_credits++;
    check_equal(32'(snd_credits <= `EXEC_FIFO_DEPTH), 32'd1, "sender credit bound");
    // result check, in issue order
    if (out_valid) begin
      if (exp_rd_q.size() == 0)
        stop_run("out_valid with no result expected");
      check_equal(32'(out_rd), 32'(exp_rd_q.pop_front()), "out_rd");
      check_equal(out_data, exp_data_q.pop_front(), "out_data");
      rcv_held++;
      check_equal(32'(rcv_held <= `EXEC_OUT_CREDITS), 32'd1, "outputs beyond credits");
    end
    // receiver hands credits back after a random delay
    out_credit <= 1'b0;
    if (rcv_held > 0) begin
      if (ret_gap == 0) begin
        out_credit <= 1'b1;
        rcv_held--;
        r = next_rand();
        ret_gap = int'(r[31:28]);
      end else begin
        ret_gap--;
      end
    end
    // sender pushes only while it holds a credit
    in_valid <= 1'b0;
    if (issued < N_INSTR) begin
      if (idle_gap > 0) begin
        idle_gap--;
      end else if (snd_credits > 0) begin
        w = make_instr();
        in_valid <= 1'b1;
        in_instr <= w;
        snd_credits--;
        issued++;
        model_issue(w);
        r = next_rand();
        idle_gap = int'(r[31:30]);
      end
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst_b      = 1'b0;
    in_valid   = 1'b0;
    in_instr   = '0;
    out_credit = 1'b0;
    for (int i = 0; i < `EXEC_REG_N; i++)
      model_regs[i] = '0;
    issued        = 0;
    snd_credits   = `EXEC_FIFO_DEPTH;
    rcv_held      = 0;
    idle_gap      = 0;
    ret_gap       = 0;
    cycle         = 0;
    repeat (2) @(posedge clk);
    rst_b <= 1'b1;
    // run until all traffic and credits are back, bounded
    while (!drained() && (cycle < MAX_CYCLES)) begin
      @(posedge clk);
      cycle++;
      cycle_step();
    end
    if (drained()) begin
      $display("TEST PASS");
      $finish;
    end else begin
      stop_run("timeout, engine did not drain all instructions and credits");
    end
  end

endmodule

// ==== exec_top.sv ====
// ****************************************
// execute engine top level
// queue, control, register file and ALU
// ****************************************
`include "exec_cfg.svh"

module exec_top
  import isa_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_b,
  input  logic                    in_valid,
  input  logic [`EXEC_DATA_W-1:0] in_instr,
  input  logic                    out_credit,
  output logic                    in_credit,
  output logic                    out_valid,
  output logic [`EXEC_REG_AW-1:0] out_rd,
  output logic [`EXEC_DATA_W-1:0] out_data
);

  // queue to control link
  logic   q_valid;
  instr_t q_instr;
  logic   q_pop;

  rf_if  rf_bus ();
  alu_if alu_bus ();

  exec_instr_fifo i_fifo (
    .clk, .rst_b, .in_valid, .in_instr(instr_t'(in_instr)),
    .q_valid, .q_instr, .q_pop, .in_credit
  );

  exec_ctrl i_ctrl (
    .clk, .rst_b, .q_valid, .q_instr, .q_pop, .out_credit,
    .out_valid, .out_rd, .out_data, .rf(rf_bus.ctrl), .alu(alu_bus.ctrl)
  );

  exec_regfile i_regfile (.clk, .rst_b, .bus(rf_bus.rf));

  exec_alu i_alu (.clk, .rst_b, .bus(alu_bus.alu));

endmodule

// ==== exec_ctrl.sv ====
// ****************************************
// execute control FSM
// sequences instructions, tracks output credits
// ****************************************
`include "exec_cfg.svh"

module exec_ctrl
  import isa_pkg::*;
  import flow_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_b,
  input  logic                    q_valid,
  input  instr_t                  q_instr,
  output logic                    q_pop,
  input  logic                    out_credit,
  output logic                    out_valid,
  output logic [`EXEC_REG_AW-1:0] out_rd,
  output logic [`EXEC_DATA_W-1:0] out_data,
  rf_if.ctrl                      rf,
  alu_if.ctrl                     alu
);

  ctrl_state_e state;
  instr_t      cur;
  credit_t     credits;
  logic        op_valid;
  logic        use_imm;
  logic        send;

  // opcode decode
  always_comb begin
    op_valid = 1'b1;
    use_imm  = 1'b0;
    case (cur.op)
      OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA: use_imm = 1'b0;
      OP_ADDI, OP_LUI: use_imm = 1'b1;
      default: op_valid = 1'b0;
    endcase
  end

  // credit spent at the edge leaving S_WRITE, so idle sees a settled count
  assign send  = (state == S_WRITE);
  assign q_pop = (state == S_IDLE) && q_valid && (credits != '0);

  // operand sources, immediate forms ignore rt
  assign rf.ra      = cur.rs;
  assign rf.rb      = cur.rt;
  assign alu.op     = cur.op;
  assign alu.opnd_a = rf.rdata_a;
  assign alu.opnd_b = use_imm ? '0 : rf.rdata_b;
  assign alu.imm    = cur.imm;
  assign alu.go     = (state == S_EXEC) && op_valid;

  // writeback in S_WRITE
  assign rf.we = send;
  assign rf.wa = cur.rd;
  assign rf.wd = alu.result;

  // result and destination stay put until the next go / pop
  assign out_rd   = cur.rd;
  assign out_data = alu.result;

  // latched instruction
  always_ff @(posedge clk) begin
    if (q_pop)
      cur <= q_instr;
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state     <= S_IDLE;
      out_valid <= 1'b0;
      credits   <= credit_t'(`EXEC_OUT_CREDITS);
    end else begin
      out_valid <= send;
      case (state)
        S_IDLE:  if (q_pop) state <= S_EXEC;
        // dropped opcodes go straight back
        S_EXEC:  state <= op_valid ? S_WRITE : S_IDLE;
        default: state <= S_IDLE;
      endcase
      // saturating up/down, send and return together cancel
      if (send && !out_credit && (credits != '0))
        credits <= credits - 1'b1;
      else if (out_credit && !send && (credits < `EXEC_OUT_CREDITS))
        credits <= credits + 1'b1;
    end
  end

  // a result only goes out on a credit still held since its pop
  a_send_credit: assert property (@(posedge clk) disable iff (!rst_b)
    send |-> (credits != '0));

  // receiver never hands back more credits than were spent
  a_credit_max: assert property (@(posedge clk) disable iff (!rst_b)
    (out_credit && !send) |-> (credits < `EXEC_OUT_CREDITS));

endmodule

// ==== exec_alu.sv ====
// ****************************************
// execute unit
// add/sub, compares, shifts, immediates
// ****************************************
`include "exec_cfg.svh"

module exec_alu
  import isa_pkg::*;
(
  input logic clk,
  input logic rst_b,
  alu_if.alu  bus
);

  logic [`EXEC_DATA_W-1:0] imm_sx;
  logic [4:0]              shamt;
  logic [`EXEC_DATA_W-1:0] nxt;

  // sign extender, 16 to data width
  assign imm_sx = {{(`EXEC_DATA_W - 16){bus.imm[15]}}, bus.imm};
  // shift amount from low bits of rt
  assign shamt  = bus.opnd_b[4:0];

  always_comb begin
    case (bus.op)
      OP_ADD:  nxt = bus.opnd_a + bus.opnd_b;
      OP_SUB:  nxt = bus.opnd_a - bus.opnd_b;
      OP_SLT:  nxt = {{(`EXEC_DATA_W - 1){1'b0}}, $signed(bus.opnd_a) < $signed(bus.opnd_b)};
      OP_SLTU: nxt = {{(`EXEC_DATA_W - 1){1'b0}}, bus.opnd_a < bus.opnd_b};
      OP_SLL:  nxt = bus.opnd_a << shamt;
      OP_SRL:  nxt = bus.opnd_a >> shamt;
      OP_SRA:  nxt = $signed(bus.opnd_a) >>> shamt;
      OP_ADDI: nxt = bus.opnd_a + imm_sx;
      // immediate into upper half, zeros below
      OP_LUI:  nxt = {bus.imm, {(`EXEC_DATA_W - 16){1'b0}}};
      // unassigned codes, never written back
      default: nxt = '0;
    endcase
  end

  // result register, loads on go only
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b)
      bus.result <= '0;
    else if (bus.go)
      bus.result <= nxt;
  end

endmodule

// ==== exec_regfile.sv ====
// ****************************************
// register file
// 8 x 32, async read, sync write
// ****************************************
`include "exec_cfg.svh"

module exec_regfile (
  input logic clk,
  input logic rst_b,
  rf_if.rf    bus
);

  logic [`EXEC_DATA_W-1:0] regs [`EXEC_REG_N];

  // read ports see the stored value, no write bypass
  // ctrl reads in S_EXEC and writes in S_WRITE so none is needed
  assign bus.rdata_a = regs[bus.ra];
  assign bus.rdata_b = regs[bus.rb];

  // all registers writable, including r0
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      for (int i = 0; i < `EXEC_REG_N; i++)
        regs[i] <= '0;
    end else if (bus.we) begin
      regs[bus.wa] <= bus.wd;
    end
  end

endmodule

// ==== exec_instr_fifo.sv ====
// ****************************************
// instruction queue
// circular buffer, returns one credit per pop
// ****************************************
`include "exec_cfg.svh"

module exec_instr_fifo
  import isa_pkg::*;
  import flow_pkg::*;
(
  input  logic   clk,
  input  logic   rst_b,
  input  logic   in_valid,
  input  instr_t in_instr,
  output logic   q_valid,
  output instr_t q_instr,
  input  logic   q_pop,
  output logic   in_credit
);

  instr_t                                 mem [`EXEC_FIFO_DEPTH];
  logic [$clog2(`EXEC_FIFO_DEPTH)-1:0]    wr_ptr;
  logic [$clog2(`EXEC_FIFO_DEPTH)-1:0]    rd_ptr;
  credit_t                                count;

  // head of queue is always presented
  assign q_valid = (count != '0);
  assign q_instr = mem[rd_ptr];

  // storage, depth is a power of two so pointers wrap naturally
  always_ff @(posedge clk) begin
    if (in_valid)
      mem[wr_ptr] <= in_instr;
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid)
        wr_ptr <= wr_ptr + 1'b1;
      if (q_pop)
        rd_ptr <= rd_ptr + 1'b1;
      // occupancy holds when push and pop coincide
      if (in_valid && !q_pop)
        count <= count + 1'b1;
      else if (q_pop && !in_valid)
        count <= count - 1'b1;
      // credit goes back to the sender the cycle after a pop
      in_credit <= q_pop;
    end
  end

  // a sender honoring its credits never pushes into a full queue
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_b)
    in_valid |-> (count != `EXEC_FIFO_DEPTH));

endmodule

// ==== exec_ifs.sv ====
// ****************************************
// register file and ALU interfaces
// ****************************************
`include "exec_cfg.svh"

// register file access, two read ports and one write port
interface rf_if;
  logic [`EXEC_REG_AW-1:0] ra;
  logic [`EXEC_REG_AW-1:0] rb;
  logic                    we;
  logic [`EXEC_REG_AW-1:0] wa;
  logic [`EXEC_DATA_W-1:0] wd;
  // combinational read data
  logic [`EXEC_DATA_W-1:0] rdata_a;
  logic [`EXEC_DATA_W-1:0] rdata_b;

  modport ctrl (output ra, rb, we, wa, wd, input rdata_a, rdata_b);
  modport rf (input ra, rb, we, wa, wd, output rdata_a, rdata_b);
endinterface

// ALU request and registered result
interface alu_if import isa_pkg::*; ();
  opcode_e                 op;
  logic [`EXEC_DATA_W-1:0] opnd_a;
  logic [`EXEC_DATA_W-1:0] opnd_b;
  logic [15:0]             imm;
  // load strobe for result
  logic                    go;
  logic [`EXEC_DATA_W-1:0] result;

  modport ctrl (output op, opnd_a, opnd_b, imm, go, input result);
  modport alu (input op, opnd_a, opnd_b, imm, go, output result);
endinterface

// ==== flow_pkg.sv ====
// ****************************************
// flow-control and sequencing types
// ****************************************
`include "exec_cfg.svh"

package flow_pkg;

  // control sequencing
  // S_IDLE  waits for an instruction and an output credit
  // S_EXEC  reads operands, ALU result loads at exit
  // S_WRITE writeback, output strobe follows
  typedef enum logic [1:0] {
    S_IDLE  = 2'd0,
    S_EXEC  = 2'd1,
    S_WRITE = 2'd2
  } ctrl_state_e;

  // wide enough to hold 0..EXEC_FIFO_DEPTH inclusive
  // also covers the smaller output credit count
  typedef logic [$clog2(`EXEC_FIFO_DEPTH + 1)-1:0] credit_t;

endpackage

// ==== isa_pkg.sv ====
// ****************************************
// instruction set types
// opcode encoding and instruction word layout
// ****************************************
`include "exec_cfg.svh"

package isa_pkg;

  // 4-bit opcode, codes 9..15 have no operation
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_SLT  = 4'd2,
    OP_SLTU = 4'd3,
    OP_SLL  = 4'd4,
    OP_SRL  = 4'd5,
    OP_SRA  = 4'd6,
    OP_ADDI = 4'd7,
    OP_LUI  = 4'd8
  } opcode_e;

  // instruction word, msb first
  // op[31:28] rd[27:25] rs[24:22] rt[21:19] unused[18:16] imm[15:0]
  typedef struct packed {
    opcode_e                 op;
    logic [`EXEC_REG_AW-1:0] rd;
    logic [`EXEC_REG_AW-1:0] rs;
    logic [`EXEC_REG_AW-1:0] rt;
    logic [2:0]              unused;
    logic [15:0]             imm;
  } instr_t;

endpackage

// ==== exec_cfg.svh ====
// ****************************************
// execute engine configuration
// widths, sizes and credit counts
// ****************************************
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// datapath and instruction word width
`define EXEC_DATA_W 32

// register file size and address width
`define EXEC_REG_N 8
`define EXEC_REG_AW 3

// instruction queue depth, also the sender's starting credit count
`define EXEC_FIFO_DEPTH 4

// output credits held by the engine after reset
`define EXEC_OUT_CREDITS 2

`endif
